// File: Bender.yml
package:
  name: tcdm

sources:
  # Design, package first
  - files:
      - rtl/tcdm_pkg.sv
      - rtl/tcdm_master_port.sv
      - rtl/tcdm_bank_arbiter.sv
      - rtl/tcdm_bank_sram.sv
      - rtl/tcdm_xbar_top.sv

  # Testbench with the bound arbiter properties
  - target: test
    files:
      - testbench/tcdm_arbiter_properties.sv
      - testbench/tcdm_tb.sv

// File: rtl/tcdm_bank_arbiter.sv
// Round-robin arbiter in front of one bank
// Forwards the winner's payload and routes the bank response back

`timescale 1ns/1ns

module tcdm_bank_arbiter
(
    input  logic                 clk,
    input  logic                 reset_i,

    // Master side, already transposed
    input  tcdm_pkg::master_id_t req_i,                              // Requests for this bank
    input  tcdm_pkg::bank_req_t  payload_i [tcdm_pkg::N_MASTER],     // Every master's payload
    output tcdm_pkg::master_id_t gnt_o,                              // One-hot or zero

    // Bank side
    output tcdm_pkg::bank_req_t  bank_req_o,
    input  tcdm_pkg::bank_rsp_t  bank_rsp_i,

    // Response back to the masters
    output tcdm_pkg::master_id_t r_valid_o,
    output tcdm_pkg::data_t      r_rdata_o
);

    // Priority mask, set bits are masters after the last winner
    tcdm_pkg::master_id_t mask_q;
    tcdm_pkg::master_id_t masked_req;
    tcdm_pkg::master_id_t pick_masked;                               // Lowest masked requester
    tcdm_pkg::master_id_t pick_any;                                  // Lowest requester overall

    //////////////////////////////////////////////////////////////////////
    // Round-robin grant
    //////////////////////////////////////////////////////////////////////

    assign masked_req  = req_i & mask_q;
    assign pick_masked = masked_req & (~masked_req + 1'b1);          // Isolate lowest set bit
    assign pick_any    = req_i & (~req_i + 1'b1);

    // Wrap to the lowest requester once the mask runs dry
    assign gnt_o = (|masked_req) ? pick_masked : pick_any;

    // Pointer moves only when someone wins
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            mask_q <= '1;                                            // Master 0 first
        end
        else if (|gnt_o)
        begin
            mask_q <= ~((gnt_o << 1) - 1'b1);                        // Everyone above the winner
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request forwarding
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        bank_req_o = '0;
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            if (gnt_o[m])
            begin
                bank_req_o = payload_i[m];                           // Winner's payload
            end
        end
        bank_req_o.req = |gnt_o;                                     // Master's own req not used
    end

    //////////////////////////////////////////////////////////////////////
    // Response routing
    //////////////////////////////////////////////////////////////////////

    // The returned ID is already one-hot, qualify it with the valid
    assign r_valid_o = bank_rsp_i.r_valid ? bank_rsp_i.r_id : '0;
    assign r_rdata_o = bank_rsp_i.r_rdata;                           // Meaningful on loads only

endmodule

// File: rtl/tcdm_bank_sram.sv
// One word-wide SRAM bank with byte enables
// Registered response carries the requester ID back

`timescale 1ns/1ns

module tcdm_bank_sram
(
    input  logic                clk,
    input  logic                reset_i,

    input  tcdm_pkg::bank_req_t req_i,      // From the bank arbiter
    output tcdm_pkg::bank_rsp_t rsp_o       // One cycle after req
);

    tcdm_pkg::data_t      mem [tcdm_pkg::N_ROWS];   // 256 words

    // Response register
    logic                 valid_q;
    tcdm_pkg::master_id_t id_q;
    tcdm_pkg::data_t      rdata_q;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Store writes only the enabled bytes
    always_ff @(posedge clk)
    begin
        if (req_i.req && !req_i.wen)
        begin
            for (int b = 0; b < tcdm_pkg::BE_WIDTH; b++)
            begin
                if (req_i.be[b])
                begin
                    mem[req_i.row][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    // Every accepted request answers, loads and stores alike
    always_ff @(posedge clk)
    begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= req_i.req;
    end

    always_ff @(posedge clk)
    begin
        if (req_i.req)
        begin
            id_q <= req_i.id;                           // Who gets the answer
            if (req_i.wen)
                rdata_q <= mem[req_i.row];              // Load, old word
        end
    end

    assign rsp_o.r_valid = valid_q;
    assign rsp_o.r_rdata = rdata_q;
    assign rsp_o.r_id    = id_q;

endmodule

// File: rtl/tcdm_master_port.sv
// Master side of the crossbar
// Bank decode, request fan-out, grant gather and response select

`timescale 1ns/1ns

module tcdm_master_port
#(
    parameter int MASTER_INDEX = 0                                 // Sets the one-hot ID
)
(
    // Master side
    input  tcdm_pkg::master_req_t req_i,
    output tcdm_pkg::master_rsp_t rsp_o,

    // Toward the bank arbiters
    output tcdm_pkg::bank_vec_t   bank_req_o,                      // One-hot bank request
    output tcdm_pkg::bank_req_t   payload_o,                       // Shared by all banks
    input  tcdm_pkg::bank_vec_t   bank_gnt_i,                      // Grant bit per bank

    // From the bank arbiters
    input  tcdm_pkg::bank_vec_t   bank_r_valid_i,                  // Valid bit per bank
    input  tcdm_pkg::data_t       bank_r_rdata_i [tcdm_pkg::N_BANK]
);

    tcdm_pkg::bank_sel_t  bank_sel;                                // Decoded bank index
    tcdm_pkg::master_id_t my_id;

    //////////////////////////////////////////////////////////////////////
    // Request path
    //////////////////////////////////////////////////////////////////////

    // Consecutive words go to consecutive banks
    assign bank_sel = req_i.addr[tcdm_pkg::BANK_SEL_LSB +: tcdm_pkg::BANK_SEL_WIDTH];
    assign my_id    = tcdm_pkg::master_id_t'(1) << MASTER_INDEX;

    always_comb
    begin
        // Exactly one bank sees the request
        bank_req_o           = '0;
        bank_req_o[bank_sel] = req_i.req;

        // Payload goes to every arbiter, only the addressed one uses it
        payload_o.req   = req_i.req;                               // Arbiter sets its own
        payload_o.wen   = req_i.wen;
        payload_o.row   = req_i.addr[tcdm_pkg::ROW_LSB +: tcdm_pkg::ROW_WIDTH];
        payload_o.wdata = req_i.wdata;
        payload_o.be    = req_i.be;
        payload_o.id    = my_id;                                   // Routes the response back
    end

    //////////////////////////////////////////////////////////////////////
    // Grant and response path
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Only the addressed bank can grant us
        rsp_o.gnt     = |(bank_gnt_i & bank_req_o);

        // At most one bank answers per cycle, one grant per cycle
        rsp_o.r_valid = |bank_r_valid_i;
        rsp_o.r_rdata = '0;
        for (int b = 0; b < tcdm_pkg::N_BANK; b++)
        begin
            if (bank_r_valid_i[b])
            begin
                rsp_o.r_rdata = bank_r_rdata_i[b];                 // Answering bank's word
            end
        end
    end

endmodule

// File: rtl/tcdm_pkg.sv
// Shared sizes, address field positions and bundle types
// for the four-master, four-bank TCDM crossbar

package tcdm_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////
    localparam int N_MASTER       = 4;      // Master ports
    localparam int N_BANK         = 4;      // Interleaved SRAM banks
    localparam int DATA_WIDTH     = 32;
    localparam int BE_WIDTH       = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH     = 32;     // Master byte address
    localparam int ROW_WIDTH      = 8;      // 256 words per bank
    localparam int N_ROWS         = 1 << ROW_WIDTH;

    // Address layout, low to high: byte offset, bank select, row
    localparam int BYTE_OFFSET    = 2;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int BANK_SEL_LSB   = BYTE_OFFSET;
    localparam int ROW_LSB        = BANK_SEL_LSB + BANK_SEL_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////////////////////////
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [BE_WIDTH-1:0]       be_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
    typedef logic [ROW_WIDTH-1:0]      row_t;
    typedef logic [N_MASTER-1:0]       master_id_t;   // One-hot, bit k is master k
    typedef logic [N_BANK-1:0]         bank_vec_t;    // One bit per bank

    // Master side bundles
    typedef struct packed {
        logic  req;
        logic  wen;      // 1 load, 0 store
        addr_t addr;
        data_t wdata;
        be_t   be;
    } master_req_t;

    typedef struct packed {
        logic  gnt;      // Same cycle as req
        logic  r_valid;  // One cycle after gnt
        data_t r_rdata;  // Loads only
    } master_rsp_t;

    // Bank side bundles, tagged with the one-hot requester
    typedef struct packed {
        logic       req;
        logic       wen;
        row_t       row;
        data_t      wdata;
        be_t        be;
        master_id_t id;
    } bank_req_t;

    typedef struct packed {
        logic       r_valid;
        data_t      r_rdata;
        master_id_t r_id;
    } bank_rsp_t;

endpackage

// File: rtl/tcdm_xbar_top.sv
// TCDM top level, four masters over four interleaved banks
// Master ports, per-bank arbiters, SRAM banks and the transposing wires

`timescale 1ns/1ns

module tcdm_xbar_top
(
    input  logic                  clk,
    input  logic                  reset_i,

    input  tcdm_pkg::master_req_t master_req_i [tcdm_pkg::N_MASTER],
    output tcdm_pkg::master_rsp_t master_rsp_o [tcdm_pkg::N_MASTER]
);

    // Indexed by master
    tcdm_pkg::bank_vec_t  mst_bank_req [tcdm_pkg::N_MASTER];
    tcdm_pkg::bank_req_t  mst_payload  [tcdm_pkg::N_MASTER];
    tcdm_pkg::bank_vec_t  mst_bank_gnt [tcdm_pkg::N_MASTER];
    tcdm_pkg::bank_vec_t  mst_r_valid  [tcdm_pkg::N_MASTER];

    // Indexed by bank
    tcdm_pkg::master_id_t arb_req      [tcdm_pkg::N_BANK];
    tcdm_pkg::master_id_t arb_gnt      [tcdm_pkg::N_BANK];
    tcdm_pkg::master_id_t arb_r_valid  [tcdm_pkg::N_BANK];
    tcdm_pkg::data_t      arb_r_rdata  [tcdm_pkg::N_BANK];  // Seen by every master port
    tcdm_pkg::bank_req_t  bank_req     [tcdm_pkg::N_BANK];
    tcdm_pkg::bank_rsp_t  bank_rsp     [tcdm_pkg::N_BANK];

    //////////////////////////////////////////////////////////////////////
    // Master ports and the transpose
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < tcdm_pkg::N_MASTER; k++)
    begin : g_master
        tcdm_master_port #(
            .MASTER_INDEX   ( k                  )
        ) i_master_port (
            .req_i          ( master_req_i[k]    ),
            .rsp_o          ( master_rsp_o[k]    ),
            .bank_req_o     ( mst_bank_req[k]    ),
            .payload_o      ( mst_payload[k]     ),
            .bank_gnt_i     ( mst_bank_gnt[k]    ),
            .bank_r_valid_i ( mst_r_valid[k]     ),
            .bank_r_rdata_i ( arb_r_rdata        )
        );

        // Master k, bank j <-> bank j, master k
        for (genvar j = 0; j < tcdm_pkg::N_BANK; j++)
        begin : g_xpose
            assign arb_req[j][k]      = mst_bank_req[k][j];
            assign mst_bank_gnt[k][j] = arb_gnt[j][k];
            assign mst_r_valid[k][j]  = arb_r_valid[j][k];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Arbiters and banks
    //////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < tcdm_pkg::N_BANK; j++)
    begin : g_bank
        tcdm_bank_arbiter i_bank_arbiter (
            .clk        ( clk            ),
            .reset_i    ( reset_i        ),
            .req_i      ( arb_req[j]     ),
            .payload_i  ( mst_payload    ),   // All masters, winner picked inside
            .gnt_o      ( arb_gnt[j]     ),
            .bank_req_o ( bank_req[j]    ),
            .bank_rsp_i ( bank_rsp[j]    ),
            .r_valid_o  ( arb_r_valid[j] ),
            .r_rdata_o  ( arb_r_rdata[j] )
        );

        tcdm_bank_sram i_bank_sram (
            .clk        ( clk            ),
            .reset_i    ( reset_i        ),
            .req_i      ( bank_req[j]    ),
            .rsp_o      ( bank_rsp[j]    )
        );
    end

endmodule

// File: tcdm.f
rtl/tcdm_pkg.sv
rtl/tcdm_master_port.sv
rtl/tcdm_bank_arbiter.sv
rtl/tcdm_bank_sram.sv
rtl/tcdm_xbar_top.sv
testbench/tcdm_arbiter_properties.sv
testbench/tcdm_tb.sv

// File: testbench/tcdm_arbiter_properties.sv
// Concurrent checks on one bank arbiter
// Grant shape and one-cycle response timing, bound into every arbiter

`timescale 1ns/1ns

module tcdm_arbiter_properties
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  tcdm_pkg::master_id_t req_i,      // Requests seen by the arbiter
    input  tcdm_pkg::master_id_t gnt_i,      // Arbiter grant
    input  tcdm_pkg::master_id_t r_valid_i   // Routed response valids
);

    // At most one winner per cycle
    grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_i))
        else $error("Arbiter grant is not one-hot: %04b", gnt_i);

    // Winner must be asking for this bank
    grant_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        (gnt_i & ~req_i) == '0)
        else $error("Grant %04b without request %04b", gnt_i, req_i);

    // Bank answers the winner exactly one cycle later
    response_follows_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        |gnt_i |=> r_valid_i == $past(gnt_i))
        else $error("Response valid %04b does not match last grant", r_valid_i);

    // No response out of nowhere
    response_needs_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        |r_valid_i |-> r_valid_i == $past(gnt_i))
        else $error("Response valid %04b without a grant", r_valid_i);

endmodule

// Attached to every bank arbiter in the crossbar
bind tcdm_bank_arbiter tcdm_arbiter_properties i_arbiter_properties (
    .clk_i     ( clk       ),
    .reset_i   ( reset_i   ),
    .req_i     ( req_i     ),
    .gnt_i     ( gnt_o     ),
    .r_valid_i ( r_valid_o )
);

// File: testbench/tcdm_tb.sv
// Testbench for the four-master TCDM crossbar
// Clock, reset, directed and random stimulus, reference memory model,
// response checking, timeout and final message

`timescale 1ns/1ns

module tcdm_tb;

    localparam int RESET_CYCLES = 10;
    localparam int N_WORDS      = 1 << (tcdm_pkg::BANK_SEL_WIDTH + tcdm_pkg::ROW_WIDTH);
    localparam int FILL_BASE    = 64;           // Random window, words 64 to 127
    localparam int FILL_WORDS   = 64;
    localparam int N_RANDOM     = 150;          // Random requests per master
    // Directed part, fill, then every random request serialized on one bank
    localparam int STIM_CYCLES    = 40 + FILL_WORDS + N_RANDOM * tcdm_pkg::N_MASTER;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RESET_CYCLES;
    localparam tcdm_pkg::addr_t WORD_FIELD =
        tcdm_pkg::addr_t'(N_WORDS - 1) << tcdm_pkg::BYTE_OFFSET;

    logic                  clk;
    logic                  reset;
    tcdm_pkg::master_req_t master_req [tcdm_pkg::N_MASTER];
    tcdm_pkg::master_rsp_t master_rsp [tcdm_pkg::N_MASTER];

    tcdm_pkg::data_t       ref_mem [N_WORDS];           // Reference memory, word addressed
    integer                seed;
    int                    cycle_count;

    // Expected responses, one slot per master is enough at fixed latency
    tcdm_pkg::master_id_t  pend_vec;                    // Granted at the previous edge
    logic                  pend_load  [tcdm_pkg::N_MASTER];
    tcdm_pkg::data_t       pend_rdata [tcdm_pkg::N_MASTER];
    logic                  rsp_known;                   // Response register out of X

    // Random program, built up front so all masters replay in lock step
    logic                  rnd_wen   [tcdm_pkg::N_MASTER][N_RANDOM];
    tcdm_pkg::addr_t       rnd_addr  [tcdm_pkg::N_MASTER][N_RANDOM];
    tcdm_pkg::data_t       rnd_wdata [tcdm_pkg::N_MASTER][N_RANDOM];
    tcdm_pkg::be_t         rnd_be    [tcdm_pkg::N_MASTER][N_RANDOM];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                          // 10 ns period
    end

    tcdm_xbar_top uut (
        .clk          ( clk        ),
        .reset_i      ( reset      ),
        .master_req_i ( master_req ),
        .master_rsp_o ( master_rsp )
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Store result, enabled bytes replace the old ones
    function automatic tcdm_pkg::data_t merge_store(tcdm_pkg::data_t old_word,
                                                    tcdm_pkg::data_t wdata,
                                                    tcdm_pkg::be_t   be);
        tcdm_pkg::data_t merged;
        merged = old_word;
        for (int b = 0; b < tcdm_pkg::BE_WIDTH; b++)
        begin
            if (be[b])
            begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Bank select and row together form the word index
    function automatic int word_index(tcdm_pkg::addr_t addr);
        return int'(addr[tcdm_pkg::BYTE_OFFSET +: tcdm_pkg::BANK_SEL_WIDTH + tcdm_pkg::ROW_WIDTH]);
    endfunction

    function automatic tcdm_pkg::data_t fill_pattern(int word);
        return {~word[15:0], word[15:0]} ^ 32'h3C96_0000;
    endfunction

    function automatic tcdm_pkg::master_id_t gnt_vector();
        tcdm_pkg::master_id_t v;
        for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
        begin
            v[k] = master_rsp[k].gnt;
        end
        return v;
    endfunction

    function automatic tcdm_pkg::master_id_t valid_vector();
        tcdm_pkg::master_id_t v;
        for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
        begin
            v[k] = master_rsp[k].r_valid;
        end
        return v;
    endfunction

    function automatic tcdm_pkg::master_id_t req_vector();
        tcdm_pkg::master_id_t v;
        for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
        begin
            v[k] = master_req[k].req;
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_rdata(string name, tcdm_pkg::data_t expected, tcdm_pkg::data_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s expected %08h actual %08h", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_gnt(string name, tcdm_pkg::master_id_t expected,
                             tcdm_pkg::master_id_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s expected %04b actual %04b", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_valid(string name, tcdm_pkg::master_id_t expected,
                               tcdm_pkg::master_id_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s expected %04b actual %04b", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers, all driving happens on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic drive_req(int m, logic wen, tcdm_pkg::addr_t addr,
                             tcdm_pkg::data_t wdata, tcdm_pkg::be_t be);
        master_req[m].req   = 1'b1;
        master_req[m].wen   = wen;
        master_req[m].addr  = addr;
        master_req[m].wdata = wdata;
        master_req[m].be    = be;
    endtask

    task automatic drive_idle(int m);
        master_req[m] = '0;
    endtask

    // Hold one request until the grant edge
    task automatic issue(int m, logic wen, tcdm_pkg::addr_t addr,
                         tcdm_pkg::data_t wdata, tcdm_pkg::be_t be);
        @(negedge clk);
        drive_req(m, wen, addr, wdata, be);
        @(posedge clk);
        while (!master_rsp[m].gnt)
        begin
            @(posedge clk);                             // Lost arbitration, keep holding
        end
    endtask

    // Master m fills its own bank inside the random window
    task automatic run_fill(int m);
        int w;
        for (int i = 0; i < FILL_WORDS / tcdm_pkg::N_MASTER; i++)
        begin
            w = FILL_BASE + i * tcdm_pkg::N_MASTER + m;
            issue(m, 1'b0, tcdm_pkg::addr_t'(w) << tcdm_pkg::BYTE_OFFSET, fill_pattern(w), '1);
        end
        @(negedge clk);
        drive_idle(m);
    endtask

    task automatic run_random(int m);
        for (int i = 0; i < N_RANDOM; i++)
        begin
            issue(m, rnd_wen[m][i], rnd_addr[m][i], rnd_wdata[m][i], rnd_be[m][i]);
        end
        @(negedge clk);
        drive_idle(m);
    endtask

    task automatic build_random();
        int     w;
        integer rnd;
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            for (int i = 0; i < N_RANDOM; i++)
            begin
                rnd = $random(seed);
                w   = FILL_BASE + (rnd[15:0] % FILL_WORDS);
                rnd_wen[m][i] = rnd[20];                // About half loads
                rnd = $random(seed);                    // Junk in the ignored bits
                rnd_addr[m][i] = (tcdm_pkg::addr_t'(rnd) & ~WORD_FIELD)
                               | (tcdm_pkg::addr_t'(w) << tcdm_pkg::BYTE_OFFSET);
                rnd_wdata[m][i] = $random(seed);
                rnd = $random(seed);
                rnd_be[m][i] = rnd[3:0];
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response checking and reference update, sampled at the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        // Covers reset too, nothing may answer there
        if (rsp_known)
        begin
            check_valid("master_rsp_o[*].r_valid", pend_vec, valid_vector());
        end
        for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
        begin
            if (pend_vec[k] && pend_load[k])
            begin
                check_rdata($sformatf("master_rsp_o[%0d].r_rdata", k), pend_rdata[k],
                            master_rsp[k].r_rdata);
            end
        end
        rsp_known = 1'b1;
        pend_vec  = '0;

        if (!reset)
        begin
            check_gnt("master_rsp_o[*].gnt without req", '0, gnt_vector() & ~req_vector());
            // Loads take the word before this edge, different banks never collide
            for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
            begin
                if (master_req[k].req && master_rsp[k].gnt)
                begin
                    pend_vec[k]   = 1'b1;
                    pend_load[k]  = master_req[k].wen;
                    pend_rdata[k] = ref_mem[word_index(master_req[k].addr)];
                end
            end
            for (int k = 0; k < tcdm_pkg::N_MASTER; k++)
            begin
                if (master_req[k].req && master_rsp[k].gnt && !master_req[k].wen)
                begin
                    ref_mem[word_index(master_req[k].addr)] =
                        merge_store(ref_mem[word_index(master_req[k].addr)],
                                    master_req[k].wdata, master_req[k].be);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, a request was never granted", cycle_count);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed        = 33;
        reset       = 1'b1;
        cycle_count = 0;
        pend_vec    = '0;
        rsp_known   = 1'b0;
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            master_req[m] = '0;
        end
        build_random();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Full store, partial store on top, load back, word 5 in bank 1
        issue(0, 1'b0, 32'h0000_0014, 32'h1122_3344, 4'b1111);
        issue(0, 1'b0, 32'h0000_0014, 32'hAABB_CCDD, 4'b0101);
        issue(0, 1'b1, 32'h0000_0014, 32'h0000_0000, 4'b0000);
        @(negedge clk);
        drive_idle(0);

        // All masters on bank 0, untouched since reset so order is 0 to 3
        // Each winner asks again at once, the second round needs the rotation
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            drive_req(m, 1'b0, tcdm_pkg::addr_t'(m) << tcdm_pkg::ROW_LSB, 32'hB0B0_0000 + m, '1);
        end
        for (int r = 0; r < 2; r++)
        begin
            for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
            begin
                @(posedge clk);
                check_gnt("master_rsp_o[*].gnt", tcdm_pkg::master_id_t'(1) << m, gnt_vector());
                @(negedge clk);
                if (r == 0)
                begin
                    drive_req(m, 1'b0, tcdm_pkg::addr_t'(m) << tcdm_pkg::ROW_LSB,
                              32'hB1B1_0000 + m, '1);
                end
                else
                begin
                    drive_idle(m);
                end
            end
        end

        // Four masters on four banks, stores then loads, all granted at once
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            drive_req(m, 1'b0, tcdm_pkg::addr_t'(16 + m) << tcdm_pkg::BYTE_OFFSET,
                      32'hD00D_0000 + m, '1);
        end
        @(posedge clk);
        check_gnt("master_rsp_o[*].gnt", '1, gnt_vector());
        @(negedge clk);
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            drive_req(m, 1'b1, tcdm_pkg::addr_t'(16 + m) << tcdm_pkg::BYTE_OFFSET, '0, '0);
        end
        @(posedge clk);
        check_gnt("master_rsp_o[*].gnt", '1, gnt_vector());
        @(negedge clk);
        for (int m = 0; m < tcdm_pkg::N_MASTER; m++)
        begin
            drive_idle(m);
        end

        // Known contents in the window, then random traffic over it
        fork
            run_fill(0);
            run_fill(1);
            run_fill(2);
            run_fill(3);
        join
        fork
            run_random(0);
            run_random(1);
            run_random(2);
            run_random(3);
        join

        repeat (3) @(negedge clk);                      // Drain the last responses
        $display("Finished with no errors");
        $finish;
    end

endmodule
